/* build.f */
noise_dir_pkg.sv
cordic_angle.sv
sector_accumulator.sv
peak_finder.sv
frame_control.sv
noise_direction_top.sv
noise_direction_assert.sv
tb_noise_direction.sv

/* cordic_angle.sv */
`timescale 1ns/10ps

module cordic_angle (
    input logic clk_in,
    input logic rst_in,
    input logic in_valid,
    input noise_dir_pkg::sample_t in_sample,
    output logic out_valid,
    output noise_dir_pkg::angle_mag_t out_data
);

    // Stage 0 is the half-plane fold, stages 1..N the iterations
    logic signed [noise_dir_pkg::CORDIC_W-1:0] x_q [0:noise_dir_pkg::CORDIC_STAGES];
    logic signed [noise_dir_pkg::CORDIC_W-1:0] y_q [0:noise_dir_pkg::CORDIC_STAGES];
    logic signed [noise_dir_pkg::CORDIC_Z_W-1:0] z_q [0:noise_dir_pkg::CORDIC_STAGES];
    logic [noise_dir_pkg::MAG_W-1:0] mag_q [0:noise_dir_pkg::CORDIC_STAGES];
    logic [noise_dir_pkg::CORDIC_STAGES:0] valid_q;

    logic signed [noise_dir_pkg::CORDIC_W-1:0] x_in;
    logic signed [noise_dir_pkg::CORDIC_W-1:0] y_in;
    logic signed [noise_dir_pkg::CORDIC_Z_W-1:0] pi_z;

    assign x_in = in_sample.x;   // Sign extended
    assign y_in = in_sample.y;
    assign pi_z = {noise_dir_pkg::ANGLE_PI_8[noise_dir_pkg::ANGLE_W-3:0], 3'b000}; // 8 x pi/8

    // Left half-plane vectors are turned by pi first
    always_ff @(posedge clk_in) begin
        if (in_sample.x < 0) begin
            x_q[0] <= -x_in;
            y_q[0] <= -y_in;
            z_q[0] <= (in_sample.y < 0) ? -pi_z : pi_z;
        end else begin
            x_q[0] <= x_in;
            y_q[0] <= y_in;
            z_q[0] <= '0;
        end
        mag_q[0] <= in_sample.mag;
    end

    for (genvar s = 0; s < noise_dir_pkg::CORDIC_STAGES; s++) begin : g_stage
        logic signed [noise_dir_pkg::CORDIC_Z_W-1:0] atan_s;

        assign atan_s = noise_dir_pkg::ATAN_TABLE[s];

        always_ff @(posedge clk_in) begin
            if (y_q[s] < 0) begin          // Below the axis, turn counterclockwise
                x_q[s+1] <= x_q[s] - (y_q[s] >>> s);
                y_q[s+1] <= y_q[s] + (x_q[s] >>> s);
                z_q[s+1] <= z_q[s] - atan_s;
            end else begin
                x_q[s+1] <= x_q[s] + (y_q[s] >>> s);
                y_q[s+1] <= y_q[s] - (x_q[s] >>> s);
                z_q[s+1] <= z_q[s] + atan_s;
            end
            mag_q[s+1] <= mag_q[s];        // Rides along untouched
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[noise_dir_pkg::CORDIC_STAGES-1:0], in_valid};
        end
    end

    // Final angle lies within a hair of +-pi, so the top bit is spare
    assign out_valid = valid_q[noise_dir_pkg::CORDIC_STAGES];
    assign out_data.angle = z_q[noise_dir_pkg::CORDIC_STAGES][noise_dir_pkg::ANGLE_W-1:0];
    assign out_data.mag = mag_q[noise_dir_pkg::CORDIC_STAGES];

endmodule

/* frame_control.sv */
`timescale 1ns/10ps

module frame_control (
    input logic clk_in,
    input logic rst_in,
    input logic sample_valid,
    input logic [noise_dir_pkg::COUNT_W-1:0] frame_count,
    input logic peak_valid,
    input logic [noise_dir_pkg::SECTOR_W-1:0] peak_sector,
    input logic result_ack,
    output logic ready,
    output logic take,
    output logic search_start,
    output logic clear,
    output logic [noise_dir_pkg::SECTOR_W-1:0] result_sector,
    output logic result_valid
);

    typedef enum logic [2:0] {
        ACCEPT,
        DRAIN,
        SEARCH,
        REPORT,
        CLEAR
    } state_t;

    state_t state;
    logic [noise_dir_pkg::COUNT_W-1:0] accept_cnt;

    assign ready = (state == ACCEPT);
    assign take = sample_valid && ready;
    assign clear = (state == CLEAR);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ACCEPT;
            accept_cnt <= '0;
            search_start <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            search_start <= 1'b0;
            case (state)
                ACCEPT: begin
                    if (take) begin
                        if (accept_cnt == noise_dir_pkg::FRAME_LEN - 1) begin
                            accept_cnt <= '0;
                            state <= DRAIN;      // ready drops next cycle
                        end else begin
                            accept_cnt <= accept_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (frame_count == noise_dir_pkg::FRAME_LEN) begin // Pipeline empty
                        search_start <= 1'b1;
                        state <= SEARCH;
                    end
                end
                SEARCH: begin
                    if (peak_valid) begin
                        result_valid <= 1'b1;
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    if (result_ack) begin
                        result_valid <= 1'b0;
                        state <= CLEAR;
                    end
                end
                default: begin
                    state <= ACCEPT;             // Sums cleared this cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == SEARCH && peak_valid) begin
            result_sector <= peak_sector;
        end
    end

endmodule

/* noise_dir_pkg.sv */
package noise_dir_pkg;

    localparam int COORD_W = 16;                  // Signed x and y
    localparam int MAG_W = 16;                    // Unsigned sample magnitude
    localparam int ANGLE_W = 16;                  // Signed 3.13, -pi to pi

    // CORDIC sizing
    localparam int CORDIC_STAGES = 16;
    localparam int CORDIC_W = COORD_W + 2;        // Room for gain and negation
    localparam int CORDIC_Z_W = ANGLE_W + 1;      // Room for overshoot near pi

    localparam int FRAME_LEN = 199;               // Samples per frame
    localparam int COUNT_W = $clog2(FRAME_LEN + 1);

    localparam int SECTORS = 16;
    localparam int SECTOR_W = $clog2(SECTORS);
    localparam int SUM_W = MAG_W + $clog2(FRAME_LEN);

    localparam logic signed [ANGLE_W-1:0] ANGLE_PI_8 = 16'sd3217;

    // atan(2^-i) scaled by 2^13
    localparam logic [0:CORDIC_STAGES-1][ANGLE_W-1:0] ATAN_TABLE = '{
        16'd6434, 16'd3798, 16'd2007, 16'd1019,
        16'd511,  16'd256,  16'd128,  16'd64,
        16'd32,   16'd16,   16'd8,    16'd4,
        16'd2,    16'd1,    16'd0,    16'd0
    };

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic [MAG_W-1:0] mag;
    } sample_t;

    typedef struct packed {
        logic signed [ANGLE_W-1:0] angle;
        logic [MAG_W-1:0] mag;
    } angle_mag_t;

    typedef logic [SECTORS-1:0][SUM_W-1:0] sector_sums_t;

endpackage

/* noise_direction_assert.sv */
`timescale 1ns/10ps

module noise_direction_assert (
    input logic clk_in,
    input logic rst_in,
    input logic ready,
    input logic result_valid,
    input logic result_ack,
    input logic [noise_dir_pkg::SECTOR_W-1:0] result_sector
);

    // Held result must not move until acknowledged
    sector_held: assert property (
        @(posedge clk_in) disable iff (rst_in)
        result_valid && !result_ack |=> $stable(result_sector)
    ) else $error("result_sector changed while waiting for result_ack");

    // No new samples while a result is pending
    no_ready_in_report: assert property (
        @(posedge clk_in) disable iff (rst_in)
        result_valid |-> !ready
    ) else $error("ready high while result_valid is high");

    valid_low_after_reset: assert property (
        @(posedge clk_in)
        rst_in |=> !result_valid
    ) else $error("result_valid high after reset");

endmodule

/* noise_direction_top.sv */
`timescale 1ns/10ps

module noise_direction_top (
    input logic clk_in,
    input logic rst_in,
    input logic sample_valid,
    input noise_dir_pkg::sample_t sample,
    input logic result_ack,
    output logic ready,
    output logic result_valid,
    output logic [noise_dir_pkg::SECTOR_W-1:0] result_sector
);

    logic take;
    logic clear;
    logic search_start;
    logic cordic_valid;
    noise_dir_pkg::angle_mag_t cordic_data;
    noise_dir_pkg::sector_sums_t sums;
    logic [noise_dir_pkg::COUNT_W-1:0] frame_count;
    logic [noise_dir_pkg::SECTOR_W-1:0] peak_sector;
    logic peak_valid;

    frame_control u_ctrl (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .sample_valid(sample_valid),
        .frame_count(frame_count),
        .peak_valid(peak_valid),
        .peak_sector(peak_sector),
        .result_ack(result_ack),
        .ready(ready),
        .take(take),
        .search_start(search_start),
        .clear(clear),
        .result_sector(result_sector),
        .result_valid(result_valid)
    );

    // Only accepted samples enter the CORDIC
    cordic_angle u_cordic (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .in_valid(take),
        .in_sample(sample),
        .out_valid(cordic_valid),
        .out_data(cordic_data)
    );

    sector_accumulator u_accum (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .in_valid(cordic_valid),
        .in_data(cordic_data),
        .clear(clear),
        .sums(sums),
        .frame_count(frame_count)
    );

    peak_finder u_peak (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(search_start),
        .sums(sums),
        .peak_sector(peak_sector),
        .peak_valid(peak_valid)
    );

endmodule

/* peak_finder.sv */
`timescale 1ns/10ps

module peak_finder (
    input logic clk_in,
    input logic rst_in,
    input logic start,
    input noise_dir_pkg::sector_sums_t sums,
    output logic [noise_dir_pkg::SECTOR_W-1:0] peak_sector,
    output logic peak_valid
);

    // Four groups of four sectors
    logic [noise_dir_pkg::SUM_W-1:0] grp_val [0:3];
    logic [noise_dir_pkg::SECTOR_W-1:0] grp_idx [0:3];
    logic [noise_dir_pkg::SUM_W-1:0] grp_val_q [0:3];
    logic [noise_dir_pkg::SECTOR_W-1:0] grp_idx_q [0:3];
    logic [noise_dir_pkg::SUM_W-1:0] best_val;
    logic [noise_dir_pkg::SECTOR_W-1:0] best_idx;
    logic s1_valid;

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        for (int g = 0; g < 4; g++) begin
            grp_val[g] = sums[4 * g];
            grp_idx[g] = {2'(g), 2'b00};
            for (int j = 1; j < 4; j++) begin
                if (sums[4 * g + j] > grp_val[g]) begin
                    grp_val[g] = sums[4 * g + j];
                    grp_idx[g] = {2'(g), 2'(j)};
                end
            end
        end
    end

    always_comb begin
        best_val = grp_val_q[0];
        best_idx = grp_idx_q[0];
        for (int g = 1; g < 4; g++) begin
            if (grp_val_q[g] > best_val) begin
                best_val = grp_val_q[g];
                best_idx = grp_idx_q[g];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            grp_val_q <= grp_val;           // Stage 1
            grp_idx_q <= grp_idx;
        end
        if (s1_valid) begin
            peak_sector <= best_idx;        // Stage 2
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid <= 1'b0;
            peak_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            peak_valid <= s1_valid;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_noise_direction -f build.f

out=$(./obj_dir/Vtb_noise_direction)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sector_accumulator.sv */
`timescale 1ns/10ps

module sector_accumulator (
    input logic clk_in,
    input logic rst_in,
    input logic in_valid,
    input noise_dir_pkg::angle_mag_t in_data,
    input logic clear,
    output noise_dir_pkg::sector_sums_t sums,
    output logic [noise_dir_pkg::COUNT_W-1:0] frame_count
);

    logic [noise_dir_pkg::SECTOR_W-1:0] sector;
    logic [noise_dir_pkg::SUM_W-1:0] mag_ext;

    // Positive angles map to 0..7 counting up from zero,
    // negative angles to 8..15 counting up from -pi
    function automatic logic [noise_dir_pkg::SECTOR_W-1:0] angle_to_sector(
        input logic signed [noise_dir_pkg::ANGLE_W-1:0] angle
    );
        int step;
        int half;
        int a;
        int k;

        step = int'(noise_dir_pkg::ANGLE_PI_8);
        half = noise_dir_pkg::SECTORS / 2;
        a = int'(angle);
        k = 0;
        if (a >= half * step) begin
            k = half;                       // +pi is the same direction as -pi
        end else if (a >= 0) begin
            for (int j = 1; j < half; j++) begin
                if (a >= j * step) begin
                    k = j;
                end
            end
        end else begin
            k = half;                       // Also catches slight undershoot of -pi
            for (int j = 1; j < half; j++) begin
                if (a >= -(half - j) * step) begin
                    k = half + j;
                end
            end
        end
        return k[noise_dir_pkg::SECTOR_W-1:0];
    endfunction

    assign sector = angle_to_sector(in_data.angle);
    assign mag_ext = {{(noise_dir_pkg::SUM_W - noise_dir_pkg::MAG_W){1'b0}}, in_data.mag};

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            sums <= '0;
            frame_count <= '0;
        end else if (in_valid) begin
            sums[sector] <= sums[sector] + mag_ext;
            frame_count <= frame_count + 1'b1;  // One per added sample
        end
    end

endmodule

/* tb_noise_direction.sv */
`timescale 1ns/10ps

module tb_noise_direction;

    logic clk_in;
    logic rst_in;
    logic sample_valid;
    noise_dir_pkg::sample_t sample;
    logic result_ack;
    logic ready;
    logic result_valid;
    logic [noise_dir_pkg::SECTOR_W-1:0] result_sector;

    // Frame being built, as the reference model sees it
    noise_dir_pkg::sample_t frame_samples [0:noise_dir_pkg::FRAME_LEN-1];
    real frame_angle [0:noise_dir_pkg::FRAME_LEN-1];

    int exp_q [$];                  // Expected sector per frame
    string name_q [$];
    int accept_total = 0;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int single_frames = 16;         // One frame per sector
    int random_frames = 4;
    int tie_frames = 2;
    real pi = 3.14159265358979;

    noise_direction_top UUT (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .sample_valid(sample_valid),
        .sample(sample),
        .result_ack(result_ack),
        .ready(ready),
        .result_valid(result_valid),
        .result_sector(result_sector)
    );

    bind noise_direction_top noise_direction_assert u_assert (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .ready(ready),
        .result_valid(result_valid),
        .result_ack(result_ack),
        .result_sector(result_sector)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // Every handshake the DUT takes, whatever the stimulus intended
    always @(posedge clk_in) begin
        if (sample_valid && ready) begin
            accept_total++;
        end
    end

    // Middle of the sector, so CORDIC error stays inside it
    function automatic real centre_angle(input int sec);
        if (sec < 8) begin
            return (real'(sec) + 0.5) * pi / 8.0;
        end
        return (real'(sec) - 15.5) * pi / 8.0;
    endfunction

    function automatic int sector_of(input real a);
        real step;
        int k;
        step = pi / 8.0;
        if (a >= 0.0) begin
            k = $rtoi(a / step);
            if (k > 7) begin
                k = 8;                      // +pi points the same way as -pi
            end
        end else begin
            k = 8 + $rtoi((a + pi) / step); // Counted up from -pi
        end
        return k;
    endfunction

    // Sector sums, then strictly largest with lowest index on a tie
    function automatic int ref_peak();
        longint sums [0:15];
        int best;
        for (int i = 0; i < 16; i++) begin
            sums[i] = 0;
        end
        for (int n = 0; n < noise_dir_pkg::FRAME_LEN; n++) begin
            sums[sector_of(frame_angle[n])] += longint'(frame_samples[n].mag);
        end
        best = 0;
        for (int i = 1; i < 16; i++) begin
            if (sums[i] > sums[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic set_sample(input int n, input int sec, input int mag);
        real a;
        real r;
        int xi;
        int yi;
        a = centre_angle(sec);
        r = real'(4000 + int'($urandom % 26001));   // Radius 4000..30000
        xi = int'(r * $cos(a));
        yi = int'(r * $sin(a));
        frame_angle[n] = a;
        frame_samples[n].x = xi[15:0];
        frame_samples[n].y = yi[15:0];
        frame_samples[n].mag = mag[15:0];
    endtask

    task automatic queue_expected(input string name);
        exp_q.push_back(ref_peak());
        name_q.push_back(name);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
            error_count++;
        end
    endtask

    // Ready is registered, so its value at the falling edge decides acceptance
    task automatic send_frame(input bit use_gaps);
        int idx;
        idx = 0;
        while (idx < noise_dir_pkg::FRAME_LEN) begin
            @(negedge clk_in);
            if (use_gaps && ($urandom % 3 == 0)) begin
                sample_valid = 1'b0;
                sample = {16'($urandom), 16'($urandom), 16'($urandom)}; // Ignored
            end else begin
                sample_valid = 1'b1;
                sample = frame_samples[idx];
                if (ready) begin
                    idx++;
                end
            end
        end
    endtask

    initial begin : stimulus
        int lo;
        int hi;
        void'($urandom(93));
        rst_in = 1'b1;
        sample_valid = 1'b0;
        sample = '0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        for (int k = 0; k < single_frames; k++) begin
            for (int n = 0; n < noise_dir_pkg::FRAME_LEN; n++) begin
                set_sample(n, k, 1 + int'($urandom % 65535));
            end
            queue_expected($sformatf("single sector %0d", k));
            send_frame(1'b0);                  // Back to back
        end

        for (int f = 0; f < random_frames; f++) begin
            for (int n = 0; n < noise_dir_pkg::FRAME_LEN; n++) begin
                set_sample(n, int'($urandom % 16), 1 + int'($urandom % 65535));
            end
            queue_expected($sformatf("random sectors %0d", f));
            send_frame(1'b1);
        end

        for (int t = 0; t < tie_frames; t++) begin
            lo = int'($urandom % 15);
            hi = lo + 1 + int'($urandom % (15 - lo));
            // 100 x 29700 against 99 x 30000, equal sums
            for (int n = 0; n < noise_dir_pkg::FRAME_LEN; n++) begin
                if (n % 2 == 0) begin
                    set_sample(n, hi, 29700);
                end else begin
                    set_sample(n, lo, 30000);
                end
            end
            queue_expected($sformatf("tie %0d and %0d", lo, hi));
            send_frame(t == 1);
        end
        @(negedge clk_in);
        sample_valid = 1'b0;
    end

    initial begin : compare
        int frame_no;
        int expected;
        int held;
        int delay;
        int errors_before;
        string name;
        result_ack = 1'b0;
        @(negedge clk_in);
        wait (!rst_in);
        for (frame_no = 0; frame_no < single_frames + random_frames + tie_frames;
             frame_no++) begin
            @(negedge clk_in);
            while (!result_valid) begin
                @(negedge clk_in);
            end
            errors_before = error_count;
            expected = exp_q.pop_front();
            name = name_q.pop_front();
            check_value("result_sector", expected, int'(result_sector));
            check_value("accepted_samples", (frame_no + 1) * noise_dir_pkg::FRAME_LEN,
                        accept_total);
            held = int'(result_sector);
            delay = int'($urandom % 31);
            repeat (delay) begin
                @(negedge clk_in);
                check_value("result_sector", held, int'(result_sector));
                check_value("ready", 0, int'(ready));   // Next frame held off
            end
            result_ack = 1'b1;
            @(negedge clk_in);
            result_ack = 1'b0;
            check_value("result_valid", 0, int'(result_valid));
            check_value("ready", 0, int'(ready));       // Sums clear now
            @(negedge clk_in);
            check_value("ready", 1, int'(ready));
            if (error_count == errors_before) begin
                pass_count++;
                $display("Frame %0d, %s: sector %0d, passed", frame_no, name, held);
            end else begin
                fail_count++;
                $display("Frame %0d, %s: expected sector %0d, failed", frame_no, name,
                         expected);
            end
        end
        $display("Frames passed: %0d, failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        int frames;
        int limit;
        frames = single_frames + random_frames + tie_frames;
        // Gaps stretch sending by about half a frame, allow a whole one
        limit = frames * (noise_dir_pkg::FRAME_LEN + 60) + frames * noise_dir_pkg::FRAME_LEN
                + 200;
        repeat (limit) @(posedge clk_in);
        $display("Timeout: the run did not complete within %0d clock cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule
